// File: Bender.yml
package:
  name: game_core_shell

sources:
  - design/shell_pkg.sv
  - design/shell_regs.sv
  - design/reset_sequencer.sv
  - design/rtc_seconds.sv
  - design/request_stretcher.sv
  - design/video_out.sv
  - design/shell_top.sv
  - target: simulation
    files:
      - testbench/shell_top_sva.sv
      - testbench/tb_shell_top.sv

// File: design/request_stretcher.sv
//////////////////////////////
// target request stretcher
// edge detect on four request lines, priority encode,
// hold request for a fixed number of cycles
//////////////////////////////

`timescale 1ns/1ps

module request_stretcher (
  input  logic                 clk_sys_57_12,
  input  logic                 reset,
  input  logic                 req_read,
  input  logic                 req_write,
  input  logic                 req_getfile,
  input  logic                 req_openfile,
  output logic                 target_request,
  output shell_pkg::req_type_t target_request_type
);

  import shell_pkg::*;

  logic [3:0] req_lines;
  logic [3:0] req_lines_q;
  logic [3:0] req_rise;
  req_type_t  rise_code;
  logic [$bits(REQ_STRETCH_CYCLES)-1:0] stretch_count;

  // bit 0 wins, read first
  assign req_lines = {req_openfile, req_getfile, req_write, req_read};
  assign req_rise  = req_lines & ~req_lines_q;

  always_comb begin
    if (req_rise[0])      rise_code = REQ_READ;
    else if (req_rise[1]) rise_code = REQ_WRITE;
    else if (req_rise[2]) rise_code = REQ_GETFILE;
    else                  rise_code = REQ_OPENFILE;
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      req_lines_q         <= '0;
      stretch_count       <= '0;
      target_request_type <= REQ_READ;
    end else begin
      req_lines_q <= req_lines;
      if (req_rise != '0) begin
        // a new edge restarts the stretch
        stretch_count       <= REQ_STRETCH_CYCLES;
        target_request_type <= rise_code;
      end else if (stretch_count != '0) begin
        stretch_count <= stretch_count - 1'b1;
      end
    end
  end

  assign target_request = (stretch_count != '0);

endmodule

// File: design/reset_sequencer.sv
//////////////////////////////
// reset sequencer
// stretches a menu reset or start press into a long core reset
//////////////////////////////

`timescale 1ns/1ps

module reset_sequencer (
  input  logic clk_sys_57_12,
  input  logic reset,
  input  logic menu_reset_pulse,
  input  logic reset_plus_en,
  input  logic start_button,
  output logic core_reset
);

  import shell_pkg::*;

  logic         reset_source;
  logic         reset_source_q;
  reset_count_t hold_timer;

  // start only counts when the host enabled it
  assign reset_source = menu_reset_pulse || (start_button && reset_plus_en);

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      reset_source_q <= 1'b0;
      hold_timer     <= '0;
    end else begin
      reset_source_q <= reset_source;
      if (reset_source && !reset_source_q) begin
        hold_timer <= RESET_HOLD_CYCLES;
      end else if (hold_timer != '0) begin
        hold_timer <= hold_timer - 1'b1;
      end
    end
  end

  //////////////////////////////
  // core reset out
  //////////////////////////////

  assign core_reset = reset || (hold_timer != '0);

endmodule

// File: design/rtc_seconds.sv
//////////////////////////////
// rtc seconds counter
// loads epoch on rtc_valid rise, then counts whole seconds
//////////////////////////////

`timescale 1ns/1ps

module rtc_seconds #(
  parameter shell_pkg::tick_count_t TICKS_PER_SECOND = shell_pkg::TICKS_PER_SECOND_DEFAULT
) (
  input  logic              clk_sys_57_12,
  input  logic              reset,
  input  logic              rtc_valid,
  input  shell_pkg::epoch_t epoch_in,
  output shell_pkg::epoch_t seconds
);

  import shell_pkg::*;

  logic        rtc_valid_q;
  tick_count_t tick_count;

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      rtc_valid_q <= 1'b0;
      tick_count  <= '0;
      seconds     <= '0;
    end else begin
      rtc_valid_q <= rtc_valid;
      if (rtc_valid && !rtc_valid_q) begin
        // fresh epoch, restart the prescaler too
        seconds    <= epoch_in;
        tick_count <= '0;
      end else if (tick_count == tick_count_t'(TICKS_PER_SECOND - 1)) begin
        seconds    <= seconds + 1'b1;
        tick_count <= '0;
      end else begin
        tick_count <= tick_count + 1'b1;
      end
    end
  end

endmodule

// File: design/shell_pkg.sv
//////////////////////////////
// shell package
// shared types, register map and timing constants
// for the game-core shell control logic
//////////////////////////////

package shell_pkg;

  // settings bus
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [2:0]  scaler_slot_t;

  // rtc
  typedef logic [31:0] epoch_t;
  typedef logic [31:0] tick_count_t;

  // reset sequencing
  typedef logic [15:0] reset_count_t;
  typedef logic [3:0]  menu_count_t;

  // target requests
  typedef logic [1:0] req_type_t;

  // pixel formats
  typedef logic [15:0] rgb565_t;
  typedef logic [23:0] rgb888_t;

  localparam req_type_t REQ_READ     = 2'd0;
  localparam req_type_t REQ_WRITE    = 2'd1;
  localparam req_type_t REQ_GETFILE  = 2'd2;
  localparam req_type_t REQ_OPENFILE = 2'd3;

  localparam reg_addr_t ADDR_MENU_RESET  = 8'h00;
  localparam reg_addr_t ADDR_RESET_PLUS  = 8'h04;
  localparam reg_addr_t ADDR_SCALER_SLOT = 8'h08;

  localparam menu_count_t  MENU_COUNT_START  = 4'd15;
  localparam reset_count_t RESET_HOLD_CYCLES = 16'd200;
  localparam logic [2:0]   REQ_STRETCH_CYCLES = 3'd7;

  localparam tick_count_t TICKS_PER_SECOND_DEFAULT = 32'd57_120_000;

endpackage

// File: design/shell_regs.sv
//////////////////////////////
// settings registers
// host writes menu reset, reset-plus enable and scaler slot,
// reads back the last two
//////////////////////////////

`timescale 1ns/1ps

module shell_regs (
  input  logic                   clk_sys_57_12,
  input  logic                   reset,
  input  shell_pkg::reg_addr_t   reg_addr,
  input  logic                   reg_wr,
  input  shell_pkg::reg_data_t   reg_wr_data,
  output shell_pkg::reg_data_t   reg_rd_data,
  output logic                   menu_reset_pulse,
  output logic                   reset_plus_en,
  output shell_pkg::scaler_slot_t scaler_slot
);

  import shell_pkg::*;

  menu_count_t menu_count;

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      menu_count    <= '0;
      reset_plus_en <= 1'b0;
      scaler_slot   <= '0;
    end else begin
      // countdown runs on its own once loaded
      if (menu_count != '0) begin
        menu_count <= menu_count - 1'b1;
      end
      if (reg_wr) begin
        case (reg_addr)
          ADDR_MENU_RESET:  menu_count    <= MENU_COUNT_START;
          ADDR_RESET_PLUS:  reset_plus_en <= reg_wr_data[0];
          ADDR_SCALER_SLOT: scaler_slot   <= reg_wr_data[2:0];
          default: ;
        endcase
      end
    end
  end

  // last count before zero
  assign menu_reset_pulse = (menu_count == menu_count_t'(1));

  always_comb begin
    reg_rd_data = '0;
    case (reg_addr)
      ADDR_RESET_PLUS:  reg_rd_data[0]   = reset_plus_en;
      ADDR_SCALER_SLOT: reg_rd_data[2:0] = scaler_slot;
      default: ;
    endcase
  end

endmodule

// File: design/shell_top.sv
//////////////////////////////
// shell top level
// settings, reset sequencing, rtc, request
// stretching and video output in one clock domain
//////////////////////////////

`timescale 1ns/1ps

module shell_top #(
  parameter shell_pkg::tick_count_t TICKS_PER_SECOND = shell_pkg::TICKS_PER_SECOND_DEFAULT
) (
  input  logic                 clk_sys_57_12,
  input  logic                 reset,
  // settings bus
  input  shell_pkg::reg_addr_t reg_addr,
  input  logic                 reg_wr,
  input  shell_pkg::reg_data_t reg_wr_data,
  output shell_pkg::reg_data_t reg_rd_data,
  // controller and rtc
  input  shell_pkg::reg_data_t cont1_key,
  input  logic                 rtc_valid,
  input  shell_pkg::epoch_t    epoch_in,
  output shell_pkg::epoch_t    rtc_seconds,
  // target requests from the core
  input  logic                 req_read,
  input  logic                 req_write,
  input  logic                 req_getfile,
  input  logic                 req_openfile,
  output logic                 target_request,
  output shell_pkg::req_type_t target_request_type,
  output logic                 core_reset,
  // video
  input  shell_pkg::rgb565_t   rgb565,
  input  logic                 de,
  input  logic                 hs,
  input  logic                 vs,
  output shell_pkg::rgb888_t   video_rgb,
  output logic                 video_de,
  output logic                 video_hs,
  output logic                 video_vs
);

  import shell_pkg::*;

  logic         menu_reset_pulse;
  logic         reset_plus_en;
  scaler_slot_t scaler_slot;

  shell_regs u_shell_regs (
    .clk_sys_57_12   (clk_sys_57_12),
    .reset           (reset),
    .reg_addr        (reg_addr),
    .reg_wr          (reg_wr),
    .reg_wr_data     (reg_wr_data),
    .reg_rd_data     (reg_rd_data),
    .menu_reset_pulse(menu_reset_pulse),
    .reset_plus_en   (reset_plus_en),
    .scaler_slot     (scaler_slot)
  );

  // start is key bit 15
  reset_sequencer u_reset_sequencer (
    .clk_sys_57_12   (clk_sys_57_12),
    .reset           (reset),
    .menu_reset_pulse(menu_reset_pulse),
    .reset_plus_en   (reset_plus_en),
    .start_button    (cont1_key[15]),
    .core_reset      (core_reset)
  );

  rtc_seconds #(
    .TICKS_PER_SECOND(TICKS_PER_SECOND)
  ) u_rtc_seconds (
    .clk_sys_57_12(clk_sys_57_12),
    .reset        (reset),
    .rtc_valid    (rtc_valid),
    .epoch_in     (epoch_in),
    .seconds      (rtc_seconds)
  );

  request_stretcher u_request_stretcher (
    .clk_sys_57_12      (clk_sys_57_12),
    .reset              (reset),
    .req_read           (req_read),
    .req_write          (req_write),
    .req_getfile        (req_getfile),
    .req_openfile       (req_openfile),
    .target_request     (target_request),
    .target_request_type(target_request_type)
  );

  video_out u_video_out (
    .clk_sys_57_12(clk_sys_57_12),
    .reset        (reset),
    .rgb565       (rgb565),
    .de           (de),
    .hs           (hs),
    .vs           (vs),
    .scaler_slot  (scaler_slot),
    .video_rgb    (video_rgb),
    .video_de     (video_de),
    .video_hs     (video_hs),
    .video_vs     (video_vs)
  );

endmodule

// File: design/video_out.sv
//////////////////////////////
// video output stage
// rgb565 to rgb888, sync delay, de widening
// and end-of-line scaler word
//////////////////////////////

`timescale 1ns/1ps

module video_out (
  input  logic                    clk_sys_57_12,
  input  logic                    reset,
  input  shell_pkg::rgb565_t      rgb565,
  input  logic                    de,
  input  logic                    hs,
  input  logic                    vs,
  input  shell_pkg::scaler_slot_t scaler_slot,
  output shell_pkg::rgb888_t      video_rgb,
  output logic                    video_de,
  output logic                    video_hs,
  output logic                    video_vs
);

  import shell_pkg::*;

  rgb888_t rgb888;
  rgb888_t rgb_q;
  rgb888_t eol_word;
  logic    de_d1;
  logic    de_d2;
  logic    video_de_d1;

  // top bits refill the low end of each channel
  assign rgb888 = {rgb565[15:11], rgb565[15:13],
                   rgb565[10:5],  rgb565[10:9],
                   rgb565[4:0],   rgb565[4:2]};

  // scaler command sits in bits 15:13
  assign eol_word = {8'h00, scaler_slot, 13'h0000};

  always_ff @(posedge clk_sys_57_12) begin
    rgb_q <= rgb888;
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (reset) begin
      de_d1       <= 1'b0;
      de_d2       <= 1'b0;
      video_de_d1 <= 1'b0;
      video_hs    <= 1'b0;
      video_vs    <= 1'b0;
    end else begin
      de_d1       <= de;
      de_d2       <= de_d1;
      video_de_d1 <= video_de;
      video_hs    <= hs;
      video_vs    <= vs;
    end
  end

  //////////////////////////////
  // one extra pixel at each line edge
  //////////////////////////////

  assign video_de  = de || de_d2;
  assign video_rgb = de_d1       ? rgb_q :
                     video_de_d1 ? eol_word : '0;

endmodule

// File: filelist.f
design/shell_pkg.sv
design/shell_regs.sv
design/reset_sequencer.sv
design/rtc_seconds.sv
design/request_stretcher.sv
design/video_out.sv
design/shell_top.sv
testbench/shell_top_sva.sv
testbench/tb_shell_top.sv

// File: testbench/shell_top_sva.sv
//////////////////////////////
// shell top assertions
// de widening, request type hold,
// request low after reset
//////////////////////////////

`timescale 1ns/1ps

module shell_top_sva (
  input logic                 clk_sys_57_12,
  input logic                 reset,
  input logic                 de,
  input logic                 video_de,
  input logic                 req_read,
  input logic                 req_write,
  input logic                 req_getfile,
  input logic                 req_openfile,
  input logic                 target_request,
  input shell_pkg::req_type_t target_request_type
);

  logic [3:0] req_lines;
  int         assert_fails = 0;

  assign req_lines = {req_openfile, req_getfile, req_write, req_read};

  // de shows up now and again two pixels later
  de_widened: assert property (@(posedge clk_sys_57_12) disable iff (reset)
    de |-> video_de ##2 video_de)
    else begin
      $error("video_de not high with de or two cycles after it");
      assert_fails++;
    end

  // type only moves on a fresh edge
  type_held: assert property (@(posedge clk_sys_57_12) disable iff (reset)
    target_request && !(|($past(req_lines) & ~$past(req_lines, 2)))
      |-> $stable(target_request_type))
    else begin
      $error("target_request_type changed without a new request edge");
      assert_fails++;
    end

  quiet_after_reset: assert property (@(posedge clk_sys_57_12)
    $fell(reset) |-> !target_request)
    else begin
      $error("target_request high in the first cycle after reset");
      assert_fails++;
    end

endmodule

bind shell_top shell_top_sva u_shell_top_sva (.*);

// File: testbench/tb_shell_top.sv
//////////////////////////////
// shell top testbench
// random stimulus from an lcg, cycle model of
// the settings, rtc, request and video rules
//////////////////////////////

`timescale 1ns/1ps

module tb_shell_top;

  import shell_pkg::*;

  localparam int TICKS          = 10;
  localparam int READBACK_OPS   = 40;
  localparam int RTC_CYCLES     = 300;
  localparam int REQ_CYCLES     = 300;
  localparam int VIDEO_CYCLES   = 400;
  // roughly twice the summed test lengths incl. two reset holds
  localparam int TIMEOUT_CYCLES = 4000;

  logic         clk_sys_57_12;
  logic         reset;
  reg_addr_t    reg_addr;
  logic         reg_wr;
  reg_data_t    reg_wr_data;
  reg_data_t    reg_rd_data;
  reg_data_t    cont1_key;
  logic         rtc_valid;
  epoch_t       epoch_in;
  epoch_t       rtc_seconds;
  logic         req_read, req_write, req_getfile, req_openfile;
  logic         target_request;
  req_type_t    target_request_type;
  logic         core_reset;
  rgb565_t      rgb565;
  logic         de, hs, vs;
  rgb888_t      video_rgb;
  logic         video_de, video_hs, video_vs;

  logic [31:0]  lcg_state = 32'h0807ed67;
  int           cycle_count = 0;
  logic         checking = 1'b0;

  // reference model state
  logic         m_plus_en;
  scaler_slot_t m_slot;
  logic         m_valid_q;
  epoch_t       m_seconds;
  int           m_ticks;
  logic [3:0]   m_req_q;
  logic [3:0]   m_rise;
  int           m_stretch;
  req_type_t    m_type;
  rgb888_t      m_rgb_q;
  logic         m_de_d1, m_de_d2, m_vde_d1, m_hs, m_vs;

  shell_top #(.TICKS_PER_SECOND(TICKS)) u_shell_top (.*);

  initial begin
    clk_sys_57_12 = 1'b0;
    forever #10 clk_sys_57_12 = ~clk_sys_57_12;
  end

  always @(posedge clk_sys_57_12) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      fail_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
  end

  // halves swapped so the low bits are the better ones
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic rgb888_t expand565(input rgb565_t p);
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
    r = p[15:11];
    g = p[10:5];
    b = p[4:0];
    return {r, r[4:2], g, g[5:4], b, b[4:2]};
  endfunction

  function automatic req_type_t rise_type(input logic [3:0] rise);
    if (rise[0])
      return REQ_READ;
    if (rise[1])
      return REQ_WRITE;
    if (rise[2])
      return REQ_GETFILE;
    return REQ_OPENFILE;
  endfunction

  function automatic reg_data_t expected_read();
    case (reg_addr)
      ADDR_RESET_PLUS:  return reg_data_t'(m_plus_en);
      ADDR_SCALER_SLOT: return reg_data_t'(m_slot);
      default:          return '0;
    endcase
  endfunction

  function automatic rgb888_t expected_rgb();
    if (m_de_d1)
      return m_rgb_q;
    // end-of-line word, slot in 15:13
    if (m_vde_d1)
      return {8'h00, m_slot, 13'h0000};
    return '0;
  endfunction

  assign m_rise = {req_openfile, req_getfile, req_write, req_read} & ~m_req_q;

  always @(posedge clk_sys_57_12) begin
    m_rgb_q <= expand565(rgb565);
    if (reset) begin
      m_plus_en <= 1'b0;
      m_slot    <= '0;
      m_valid_q <= 1'b0;
      m_seconds <= '0;
      m_ticks   <= 0;
      m_req_q   <= '0;
      m_stretch <= 0;
      m_type    <= REQ_READ;
      {m_de_d1, m_de_d2, m_vde_d1, m_hs, m_vs} <= '0;
    end else begin
      if (reg_wr && reg_addr == ADDR_RESET_PLUS)
        m_plus_en <= reg_wr_data[0];
      if (reg_wr && reg_addr == ADDR_SCALER_SLOT)
        m_slot <= reg_wr_data[2:0];
      m_valid_q <= rtc_valid;
      if (rtc_valid && !m_valid_q) begin
        m_seconds <= epoch_in;
        m_ticks   <= 0;
      end else if (m_ticks == TICKS - 1) begin
        m_seconds <= m_seconds + 1;
        m_ticks   <= 0;
      end else begin
        m_ticks <= m_ticks + 1;
      end
      m_req_q <= {req_openfile, req_getfile, req_write, req_read};
      if (m_rise != '0) begin
        m_stretch <= REQ_STRETCH_CYCLES;
        m_type    <= rise_type(m_rise);
      end else if (m_stretch != 0) begin
        m_stretch <= m_stretch - 1;
      end
      m_de_d1  <= de;
      m_de_d2  <= m_de_d1;
      m_vde_d1 <= de || m_de_d2;
      m_hs     <= hs;
      m_vs     <= vs;
    end
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_data(input string name, input reg_data_t expected,
                            input reg_data_t actual);
    if (expected !== actual)
      fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_rgb(input string name, input rgb888_t expected,
                           input rgb888_t actual);
    if (expected !== actual)
      fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_epoch(input string name, input epoch_t expected,
                             input epoch_t actual);
    if (expected !== actual)
      fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_type(input string name, input req_type_t expected,
                            input req_type_t actual);
    if (expected !== actual)
      fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual)
      fail_run($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk_sys_57_12) begin
    if (checking) begin
      check_data("settings readback", expected_read(), reg_rd_data);
      check_epoch("rtc seconds", m_seconds, rtc_seconds);
      check_bit("target request", m_stretch != 0, target_request);
      check_type("target request type", m_type, target_request_type);
      check_bit("video de", de || m_de_d2, video_de);
      check_bit("video hs", m_hs, video_hs);
      check_bit("video vs", m_vs, video_vs);
      check_rgb("video rgb", expected_rgb(), video_rgb);
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(posedge clk_sys_57_12);
    reg_addr    <= addr;
    reg_wr      <= 1'b1;
    reg_wr_data <= data;
    @(posedge clk_sys_57_12);
    reg_wr <= 1'b0;
  endtask

  task automatic readback_test();
    logic [31:0] r;
    repeat (READBACK_OPS) begin
      r = next_random();
      @(posedge clk_sys_57_12);
      case (r[1:0])
        2'd0:    reg_addr <= ADDR_RESET_PLUS;
        2'd1:    reg_addr <= ADDR_SCALER_SLOT;
        // unmapped, never 0x00
        default: reg_addr <= r[15:8] | 8'h10;
      endcase
      reg_wr      <= r[2];
      reg_wr_data <= next_random();
    end
    @(posedge clk_sys_57_12);
    reg_wr <= 1'b0;
  endtask

  task automatic expect_core_reset_pulse(input string what);
    int waited;
    int held;
    waited = 0;
    held   = 0;
    while (!core_reset) begin
      @(negedge clk_sys_57_12);
      waited++;
      if (waited > 20)
        fail_run({what, ": core_reset did not rise within 20 cycles"});
    end
    while (core_reset) begin
      @(negedge clk_sys_57_12);
      held++;
      if (held > RESET_HOLD_CYCLES + 20)
        fail_run({what, ": core_reset stayed high too long"});
    end
    if (held < RESET_HOLD_CYCLES)
      fail_run({what, ": core_reset fell before the hold time"});
  endtask

  task automatic start_button_test();
    write_reg(ADDR_RESET_PLUS, 32'h0);
    @(posedge clk_sys_57_12);
    cont1_key <= next_random() | 32'h0000_8000;
    repeat (30) begin
      @(negedge clk_sys_57_12);
      check_bit("start with reset-plus off", 1'b0, core_reset);
    end
    @(posedge clk_sys_57_12);
    cont1_key <= '0;
    write_reg(ADDR_RESET_PLUS, 32'h1);
    @(posedge clk_sys_57_12);
    cont1_key <= 32'h0000_8000;
    expect_core_reset_pulse("start button");
    @(posedge clk_sys_57_12);
    cont1_key <= '0;
    write_reg(ADDR_RESET_PLUS, 32'h0);
  endtask

  task automatic rtc_test();
    repeat (2) begin
      @(posedge clk_sys_57_12);
      epoch_in  <= next_random();
      rtc_valid <= 1'b1;
      repeat (RTC_CYCLES / 2) begin
        @(posedge clk_sys_57_12);
        rtc_valid <= 1'b0;
        // ignored while rtc_valid stays low
        epoch_in  <= next_random();
      end
    end
  endtask

  task automatic request_test();
    logic [31:0] r;
    repeat (REQ_CYCLES) begin
      r = next_random();
      @(posedge clk_sys_57_12);
      if (r[2:0] == 3'd0)
        {req_openfile, req_getfile, req_write, req_read} <= r[11:8];
    end
    @(posedge clk_sys_57_12);
    {req_openfile, req_getfile, req_write, req_read} <= '0;
  endtask

  task automatic video_test();
    logic [31:0] r;
    repeat (4) begin
      write_reg(ADDR_SCALER_SLOT, next_random());
      repeat (VIDEO_CYCLES / 4) begin
        r = next_random();
        @(posedge clk_sys_57_12);
        rgb565 <= r[31:16];
        if (r[1:0] == 2'd0)
          de <= ~de;
        hs <= (r[7:4] == 4'd0);
        vs <= (r[11:8] == 4'd0);
      end
    end
  endtask

  initial begin
    reset       = 1'b1;
    reg_addr    = '0;
    reg_wr      = 1'b0;
    reg_wr_data = '0;
    cont1_key   = '0;
    rtc_valid   = 1'b0;
    epoch_in    = '0;
    rgb565      = '0;
    {req_openfile, req_getfile, req_write, req_read} = '0;
    {de, hs, vs} = '0;
    repeat (4) @(posedge clk_sys_57_12);
    reset    <= 1'b0;
    checking <= 1'b1;
    readback_test();
    write_reg(ADDR_MENU_RESET, next_random());
    expect_core_reset_pulse("menu reset");
    start_button_test();
    rtc_test();
    request_test();
    video_test();
    // lets the last two-cycle assertion attempts finish
    repeat (4) @(posedge clk_sys_57_12);
    if (u_shell_top.u_shell_top_sva.assert_fails != 0) begin
      fail_run("bound assertions reported failures");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule
